// File: verilog/fetch_pkg.sv
package fetch_pkg;

	// cluster shape
	localparam int num_harts = 2;
	localparam int hart_w    = 1;          // bits in a hart index

	localparam logic [31:0] reset_pc  = 32'h4000_0000;   // first fetch after wake-up
	localparam logic [31:0] nop_instr = 32'h0000_0033;   // add x0, x0, x0

	// size field sent with every instruction fill
	localparam logic [2:0] fetch_size = 3'b000;

	// L1.5 request types, only the fill is issued here
	typedef enum logic [4:0] {
		rq_ifill = 5'b00000
	} l15_rqtype_e;

	// L1.5 return types
	typedef enum logic [3:0] {
		ret_load      = 4'b0000,
		ret_ifill     = 4'b0001,
		ret_strload   = 4'b0010,
		ret_inv       = 4'b0011,
		ret_st_ack    = 4'b0100,
		ret_test      = 4'b0101,
		ret_strst_ack = 4'b0110,
		ret_int       = 4'b0111,   // interrupt return, wakes a hart
		ret_fp        = 4'b1000,
		ret_fwd_rq    = 4'b1010,
		ret_fwd_rpy   = 4'b1011,
		ret_err       = 4'b1100,
		ret_rsvd      = 4'b1111
	} l15_rettype_e;

	// fetch stage FSM
	typedef enum logic [1:0] {
		st_req      = 2'd0,    // request on the port
		st_wait_ack = 2'd1,    // header taken, ack not yet seen
		st_resp     = 2'd2     // waiting for the fill return
	} fetch_state_e;

endpackage

// File: verilog/l15_req_if.sv
`timescale 1ns/100ps

interface l15_req_if import fetch_pkg::*; ();

	// request, driven by the stage
	logic        val;
	l15_rqtype_e rqtype;
	logic [2:0]  size;
	logic [31:0] address;
	logic        header_ack;
	logic        ack;

	// response, only the owner's fill return shows up here
	logic         resp_val;
	logic [63:0]  data_0;
	logic [63:0]  data_1;
	l15_rettype_e returntype;
	logic         req_ack;

	modport fetch (
		output val, rqtype, size, address, req_ack,
		input  header_ack, ack, resp_val, data_0, data_1, returntype
	);

	modport port (
		input  val, rqtype, size, address, req_ack,
		output header_ack, ack, resp_val, data_0, data_1, returntype
	);

endinterface

// File: verilog/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage import fetch_pkg::*; (
	input  logic        clk,
	input  logic        nrst,
	input  logic        wake,
	input  logic        redirect,
	input  logic [31:0] target,
	input  logic        exception,
	input  logic [31:0] epc,
	input  logic        stall,
	output logic        instr_valid,
	output logic [31:0] instr,
	output logic [31:0] pc,
	l15_req_if.fetch    l15
);

	fetch_state_e state;

	logic [31:0] fetch_pc;     // address of the current request
	logic [31:0] npc;
	logic [31:0] pend_pc;      // saved redirect target or epc
	logic        pend_exc;     // saved address came from an exception
	logic        kill;         // word in flight is stale

	logic        req_fire;
	logic        resp_fire;
	logic        take_new;
	logic [31:0] new_addr;
	logic        discard;
	logic [31:0] line_word;

	// exception beats redirect, also against one already saved
	assign take_new = exception || (redirect && !pend_exc);
	assign new_addr = exception ? epc : target;

	assign req_fire  = l15.val && l15.header_ack;
	assign resp_fire = (state == st_resp) && l15.resp_val && (l15.returntype == ret_ifill);
	assign discard   = kill || redirect || exception || stall;

	always_comb
	begin
		if (take_new)
			npc = new_addr;             // redirect in the response cycle
		else if (kill)
			npc = pend_pc;
		else if (discard)
			npc = fetch_pc;             // stalled, fetch the same word again
		else
			npc = fetch_pc + 32'd4;
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			state    <= st_req;
			fetch_pc <= reset_pc;
			pend_exc <= 1'b0;
			kill     <= 1'b0;
		end
		else
		begin
			case (state)
				st_req:
				begin
					if (req_fire)
						state <= l15.ack ? st_resp : st_wait_ack;
				end
				st_wait_ack:
				begin
					if (l15.ack)
						state <= st_resp;
				end
				st_resp:
				begin
					if (resp_fire)
						state <= st_req;
				end
				default:
					state <= st_req;
			endcase

			if (resp_fire)
			begin
				fetch_pc <= npc;
				kill     <= 1'b0;
				pend_exc <= 1'b0;
			end
			else if (!wake)
			begin
				// asleep, nothing in flight to throw away
				if (take_new)
					fetch_pc <= new_addr;
			end
			else if (take_new)
			begin
				kill     <= 1'b1;
				pend_exc <= pend_exc || exception;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (take_new)
			pend_pc <= new_addr;
	end

	// pick the word out of the 128-bit line
	always_comb
	begin
		case (fetch_pc[3:2])
			2'b00: line_word = l15.data_0[63:32];
			2'b01: line_word = l15.data_0[31:0];
			2'b10: line_word = l15.data_1[63:32];
			default: line_word = l15.data_1[31:0];
		endcase
	end

	assign instr_valid = resp_fire && !discard;
	assign instr       = instr_valid ? {line_word[7:0], line_word[15:8],
		line_word[23:16], line_word[31:24]} : nop_instr;   // big to little endian
	assign pc          = fetch_pc;

	// request side, address held until header_ack
	assign l15.val     = wake && (state == st_req);
	assign l15.rqtype  = rq_ifill;
	assign l15.size    = fetch_size;
	assign l15.address = fetch_pc;
	assign l15.req_ack = resp_fire;    // taken in the same cycle

endmodule

// File: verilog/redirect_router.sv
`timescale 1ns/100ps

module redirect_router import fetch_pkg::*; (
	input  logic                        clk,
	input  logic                        nrst,
	input  logic                        redirect_valid,
	input  logic [hart_w-1:0]           redirect_hart,
	input  logic [31:0]                 redirect_target,
	input  logic                        exc_valid,
	input  logic [hart_w-1:0]           exc_hart,
	input  logic [31:0]                 exc_epc,
	input  logic [num_harts-1:0]        stall,
	input  logic                        rsp_val,
	input  l15_rettype_e                rsp_returntype,
	input  logic [hart_w-1:0]           rsp_threadid,
	output logic [num_harts-1:0]        wake,
	output logic [num_harts-1:0]        hart_redirect,
	output logic [num_harts-1:0][31:0]  hart_target,
	output logic [num_harts-1:0]        hart_exc,
	output logic [num_harts-1:0][31:0]  hart_epc,
	output logic [num_harts-1:0]        hart_stall
);

	logic int_ret;

	assign int_ret = rsp_val && (rsp_returntype == ret_int);

	// one-hot fan-out of the core's commands
	always_comb
	begin
		for (int h = 0; h < num_harts; h++)
		begin
			hart_redirect[h] = redirect_valid && (redirect_hart == hart_w'(h));
			hart_target[h]   = redirect_target;
			hart_exc[h]      = exc_valid && (exc_hart == hart_w'(h));
			hart_epc[h]      = exc_epc;
		end
	end

	assign hart_stall = stall;

	// wake flags, only reset clears them
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			wake <= '0;
		end
		else if (int_ret)
		begin
			wake[rsp_threadid] <= 1'b1;
		end
	end

endmodule

// File: verilog/l15_arbiter.sv
`timescale 1ns/100ps

module l15_arbiter import fetch_pkg::*; (
	input  logic              clk,
	input  logic              nrst,
	l15_req_if.port           req [num_harts],
	output logic              transducer_l15_val,
	output logic [4:0]        transducer_l15_rqtype,
	output logic [2:0]        transducer_l15_size,
	output logic [31:0]       transducer_l15_address,
	output logic [hart_w-1:0] transducer_l15_threadid,
	input  logic              l15_transducer_header_ack,
	input  logic              l15_transducer_ack,
	input  logic              l15_transducer_val,
	input  logic [63:0]       l15_transducer_data_0,
	input  logic [63:0]       l15_transducer_data_1,
	input  logic [3:0]        l15_transducer_returntype,
	input  logic [hart_w-1:0] l15_transducer_threadid,
	output logic              transducer_l15_req_ack,
	output logic              rsp_val,
	output l15_rettype_e      rsp_returntype,
	output logic [hart_w-1:0] rsp_threadid
);

	logic [num_harts-1:0]       val_v;
	logic [num_harts-1:0]       rack_v;
	logic [num_harts-1:0][31:0] addr_v;
	logic [num_harts-1:0][2:0]  size_v;
	l15_rqtype_e                rqtype_v [num_harts];

	logic              outstanding;   // one fill in flight at the port
	logic [hart_w-1:0] owner;
	logic [hart_w-1:0] last;          // last granted hart
	logic [hart_w-1:0] rr_pick;
	logic [hart_w-1:0] winner;
	logic              hold;          // port val seen without header_ack
	logic [hart_w-1:0] hold_idx;
	logic              grant;
	logic              fill_ret;
	l15_rettype_e      rettype;

	for (genvar h = 0; h < num_harts; h++)
	begin : g_port
		assign val_v[h]    = req[h].val;
		assign rack_v[h]   = req[h].req_ack;
		assign addr_v[h]   = req[h].address;
		assign size_v[h]   = req[h].size;
		assign rqtype_v[h] = req[h].rqtype;

		assign req[h].header_ack = grant && (winner == hart_w'(h));
		assign req[h].ack        = l15_transducer_ack && ((outstanding && owner == hart_w'(h))
			|| (grant && winner == hart_w'(h)));
		assign req[h].resp_val   = fill_ret && outstanding && (owner == hart_w'(h));
		assign req[h].data_0     = l15_transducer_data_0;
		assign req[h].data_1     = l15_transducer_data_1;
		assign req[h].returntype = rettype;
	end

	// round-robin, nearest requester after last wins
	always_comb
	begin
		rr_pick = last;
		for (int i = num_harts; i >= 1; i--)
		begin
			if (val_v[(int'(last) + i) % num_harts])
				rr_pick = hart_w'((int'(last) + i) % num_harts);
		end
	end

	assign winner = hold ? hold_idx : rr_pick;   // keep the port stable until header_ack
	assign grant  = transducer_l15_val && l15_transducer_header_ack;

	assign transducer_l15_val      = !outstanding && (|val_v);
	assign transducer_l15_rqtype   = rqtype_v[winner];
	assign transducer_l15_size     = size_v[winner];
	assign transducer_l15_address  = addr_v[winner];
	assign transducer_l15_threadid = winner;

	// responses
	assign rettype  = l15_rettype_e'(l15_transducer_returntype);
	assign fill_ret = l15_transducer_val && (rettype == ret_ifill);

	assign transducer_l15_req_ack = (fill_ret && outstanding) ? rack_v[owner] : l15_transducer_val;
	assign rsp_val        = l15_transducer_val && !fill_ret;   // interrupts and the rest
	assign rsp_returntype = rettype;
	assign rsp_threadid   = l15_transducer_threadid;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			outstanding <= 1'b0;
			owner       <= '0;
			last        <= '0;
			hold        <= 1'b0;
			hold_idx    <= '0;
		end
		else
		begin
			if (grant)
			begin
				outstanding <= 1'b1;
				owner       <= winner;
				last        <= winner;
			end
			else if (fill_ret && outstanding && transducer_l15_req_ack)
			begin
				outstanding <= 1'b0;
			end
			hold     <= transducer_l15_val && !l15_transducer_header_ack;
			hold_idx <= winner;
		end
	end

endmodule

// File: verilog/fetch_cluster.sv
`timescale 1ns/100ps

module fetch_cluster import fetch_pkg::*; (
	input  logic                       clk,
	input  logic                       nrst,

	// core side
	input  logic                       redirect_valid,
	input  logic [hart_w-1:0]          redirect_hart,
	input  logic [31:0]                redirect_target,
	input  logic                       exc_valid,
	input  logic [hart_w-1:0]          exc_hart,
	input  logic [31:0]                exc_epc,
	input  logic [num_harts-1:0]       stall,
	output logic [num_harts-1:0]       instr_valid,
	output logic [num_harts-1:0][31:0] instr,
	output logic [num_harts-1:0][31:0] instr_pc,

	// L1.5 request
	output logic                       transducer_l15_val,
	output logic [4:0]                 transducer_l15_rqtype,
	output logic [2:0]                 transducer_l15_size,
	output logic [31:0]                transducer_l15_address,
	output logic [hart_w-1:0]          transducer_l15_threadid,
	input  logic                       l15_transducer_header_ack,
	input  logic                       l15_transducer_ack,

	// L1.5 response
	input  logic                       l15_transducer_val,
	input  logic [63:0]                l15_transducer_data_0,
	input  logic [63:0]                l15_transducer_data_1,
	input  logic [3:0]                 l15_transducer_returntype,
	input  logic [hart_w-1:0]          l15_transducer_threadid,
	output logic                       transducer_l15_req_ack
);

	logic [num_harts-1:0]       wake;
	logic [num_harts-1:0]       hart_redirect;
	logic [num_harts-1:0][31:0] hart_target;
	logic [num_harts-1:0]       hart_exc;
	logic [num_harts-1:0][31:0] hart_epc;
	logic [num_harts-1:0]       hart_stall;
	logic                       rsp_val;
	l15_rettype_e               rsp_returntype;
	logic [hart_w-1:0]          rsp_threadid;

	l15_req_if l15 [num_harts] ();

	redirect_router u_router (
		.clk             (clk),
		.nrst            (nrst),
		.redirect_valid  (redirect_valid),
		.redirect_hart   (redirect_hart),
		.redirect_target (redirect_target),
		.exc_valid       (exc_valid),
		.exc_hart        (exc_hart),
		.exc_epc         (exc_epc),
		.stall           (stall),
		.rsp_val         (rsp_val),
		.rsp_returntype  (rsp_returntype),
		.rsp_threadid    (rsp_threadid),
		.wake            (wake),
		.hart_redirect   (hart_redirect),
		.hart_target     (hart_target),
		.hart_exc        (hart_exc),
		.hart_epc        (hart_epc),
		.hart_stall      (hart_stall)
	);

	for (genvar h = 0; h < num_harts; h++)
	begin : g_hart
		fetch_stage u_stage (
			.clk         (clk),
			.nrst        (nrst),
			.wake        (wake[h]),
			.redirect    (hart_redirect[h]),
			.target      (hart_target[h]),
			.exception   (hart_exc[h]),
			.epc         (hart_epc[h]),
			.stall       (hart_stall[h]),
			.instr_valid (instr_valid[h]),
			.instr       (instr[h]),
			.pc          (instr_pc[h]),
			.l15         (l15[h])
		);
	end

	l15_arbiter u_arb (
		.clk                       (clk),
		.nrst                      (nrst),
		.req                       (l15),
		.transducer_l15_val        (transducer_l15_val),
		.transducer_l15_rqtype     (transducer_l15_rqtype),
		.transducer_l15_size       (transducer_l15_size),
		.transducer_l15_address    (transducer_l15_address),
		.transducer_l15_threadid   (transducer_l15_threadid),
		.l15_transducer_header_ack (l15_transducer_header_ack),
		.l15_transducer_ack        (l15_transducer_ack),
		.l15_transducer_val        (l15_transducer_val),
		.l15_transducer_data_0     (l15_transducer_data_0),
		.l15_transducer_data_1     (l15_transducer_data_1),
		.l15_transducer_returntype (l15_transducer_returntype),
		.l15_transducer_threadid   (l15_transducer_threadid),
		.transducer_l15_req_ack    (transducer_l15_req_ack),
		.rsp_val                   (rsp_val),
		.rsp_returntype            (rsp_returntype),
		.rsp_threadid              (rsp_threadid)
	);

endmodule

// File: test/tb_fetch_cluster.sv
`timescale 1ns/100ps

module tb_fetch_cluster import fetch_pkg::*; ();

	typedef enum {
		cmd_wake,
		cmd_redirect,
		cmd_exception,
		cmd_exc_redirect,   // exception and redirect in the same cycle
		cmd_stall_on,
		cmd_stall_off
	} cmd_e;

	typedef struct {
		int          offset;   // cycles after the previous row
		cmd_e        cmd;
		int          hart;
		logic [31:0] addr;
	} row_t;

	typedef enum {cm_idle, cm_hold, cm_fill, cm_resp} model_state_e;

	logic                       clk = 1'b0;
	logic                       nrst;
	logic                       redirect_valid;
	logic [hart_w-1:0]          redirect_hart;
	logic [31:0]                redirect_target;
	logic                       exc_valid;
	logic [hart_w-1:0]          exc_hart;
	logic [31:0]                exc_epc;
	logic [num_harts-1:0]       stall;
	logic [num_harts-1:0]       instr_valid;
	logic [num_harts-1:0][31:0] instr;
	logic [num_harts-1:0][31:0] instr_pc;
	logic                       transducer_l15_val;
	logic [4:0]                 transducer_l15_rqtype;
	logic [2:0]                 transducer_l15_size;
	logic [31:0]                transducer_l15_address;
	logic [hart_w-1:0]          transducer_l15_threadid;
	logic                       l15_transducer_header_ack;
	logic                       l15_transducer_ack;
	logic                       l15_transducer_val;
	logic [63:0]                l15_transducer_data_0;
	logic [63:0]                l15_transducer_data_1;
	logic [3:0]                 l15_transducer_returntype;
	logic [hart_w-1:0]          l15_transducer_threadid;
	logic                       transducer_l15_req_ack;

	row_t         rows[$];
	int           wake_q[$];      // harts waiting for an interrupt return
	int           cycle_cnt;
	int           cycle_limit;
	logic [31:0]  lcg_state;
	model_state_e cm_state;
	int           hold_cnt;
	int           lat_cnt;

	// scoreboard
	logic [num_harts-1:0] awake_exp;
	logic [31:0]          exp_pc [num_harts];
	int                   delivered [num_harts];
	logic                 fill_taken;
	logic                 held;          // port request seen without header_ack
	logic [31:0]          held_addr;
	logic [hart_w-1:0]    held_tid;
	logic [31:0]          grant_addr;
	logic [hart_w-1:0]    grant_tid;
	logic [hart_w-1:0]    last_tid;
	logic                 both_prev;     // both harts awake at the last grant
	int                   alt_checks;

	fetch_cluster dut_i (.*);

	always #50 clk = ~clk;

	function automatic int next_random(input int span);
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return int'(lcg_state[30:16]) % span;
	endfunction

	// memory contents, a fixed function of the full address
	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		return {addr[15:0], addr[31:16]} ^ (addr * 32'h9e37_79b1);
	endfunction

	function automatic logic [31:0] swap_bytes(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_pc(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("CHECK FAILED at %0t: %s, pc %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_instr(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("CHECK FAILED at %0t: %s, instr %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_rettype(input l15_rettype_e got, input l15_rettype_e exp,
		input string what);
		if (got !== exp)
			stop_on_error($sformatf("CHECK FAILED at %0t: %s, return type %s, expected %s",
				$time, what, got.name(), exp.name()));
	endtask

	task automatic check_hart(input logic [hart_w-1:0] got, input logic [hart_w-1:0] exp,
		input string what);
		if (got !== exp)
			stop_on_error($sformatf("CHECK FAILED at %0t: %s, hart %0d, expected %0d",
				$time, what, got, exp));
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("CHECK FAILED at %0t: %s, flag %b, expected %b",
				$time, what, got, exp));
	endtask

	task automatic add_row(input int offset, input cmd_e cmd, input int hart,
		input logic [31:0] addr);
		row_t r;
		r.offset = offset;
		r.cmd    = cmd;
		r.hart   = hart;
		r.addr   = addr;
		rows.push_back(r);
	endtask

	task automatic load_table();
		add_row(3,  cmd_wake,         0, 32'h0);
		add_row(30, cmd_redirect,     0, 32'h4000_0100);
		add_row(25, cmd_wake,         1, 32'h0);
		add_row(30, cmd_stall_on,     1, 32'h0);
		add_row(15, cmd_stall_off,    1, 32'h0);
		add_row(10, cmd_exception,    0, 32'h4000_0200);
		add_row(20, cmd_redirect,     1, 32'h4000_0300);
		add_row(20, cmd_exc_redirect, 1, 32'h4000_0400);
		add_row(20, cmd_stall_on,     0, 32'h0);
		add_row(12, cmd_stall_off,    0, 32'h0);
		add_row(15, cmd_redirect,     0, 32'h4000_0508);   // word 2 of the line
		add_row(20, cmd_exception,    1, 32'h4000_060c);
		add_row(30, cmd_redirect,     1, 32'h4000_0704);
	endtask

	task automatic apply_row(input row_t r);
		case (r.cmd)
			cmd_wake: wake_q.push_back(r.hart);
			cmd_stall_on: stall[r.hart] = 1'b1;
			cmd_stall_off: stall[r.hart] = 1'b0;
			default:
			begin
				redirect_valid  = (r.cmd != cmd_exception);
				redirect_hart   = hart_w'(r.hart);
				redirect_target = (r.cmd == cmd_exc_redirect) ? r.addr + 32'h80 : r.addr;
				exc_valid       = (r.cmd != cmd_redirect);
				exc_hart        = hart_w'(r.hart);
				exc_epc         = r.addr;
				@(negedge clk);
				redirect_valid = 1'b0;
				exc_valid      = 1'b0;
			end
		endcase
	endtask

	task automatic clear_scoreboard();
		awake_exp  = '0;
		fill_taken = 1'b0;
		held       = 1'b0;
		held_addr  = '0;
		held_tid   = '0;
		grant_addr = '0;
		grant_tid  = '0;
		last_tid   = '0;
		both_prev  = 1'b0;
		alt_checks = 0;
		cycle_cnt  = 0;
		for (int h = 0; h < num_harts; h++)
		begin
			exp_pc[h]    = reset_pc;
			delivered[h] = 0;
		end
	endtask

	// request side of the port
	task automatic watch_port();
		logic [hart_w-1:0] tid;
		tid = transducer_l15_threadid;
		if (transducer_l15_val)
			check_flag(awake_exp[tid], 1'b1, "request from a sleeping hart");
		check_flag(transducer_l15_val && !l15_transducer_header_ack
			&& (cm_state == cm_fill || cm_state == cm_resp), 1'b0,
			"second request while a fill is outstanding");
		if (held)
		begin
			check_flag(transducer_l15_val, 1'b1, "request withdrawn under back-pressure");
			check_pc(transducer_l15_address, held_addr, "address under back-pressure");
			check_hart(tid, held_tid, "threadid under back-pressure");
		end
		held      = transducer_l15_val && !l15_transducer_header_ack;
		held_addr = transducer_l15_address;
		held_tid  = tid;
		if (transducer_l15_val && l15_transducer_header_ack)
		begin
			check_flag(transducer_l15_rqtype == rq_ifill, 1'b1, "request type of a fetch");
			check_flag(transducer_l15_size === fetch_size, 1'b1, "size of a fetch");
			if (both_prev)
			begin
				check_hart(tid, ~last_tid, "round-robin grant");
				alt_checks++;
			end
			last_tid   = tid;
			both_prev  = &awake_exp;
			grant_addr = transducer_l15_address;
			grant_tid  = tid;
		end
	endtask

	// fetch outputs of one hart against the expected pc stream
	task automatic watch_hart(input int h);
		logic [hart_w-1:0] hid;
		logic              hit_exc;
		logic              hit_redir;
		hid       = hart_w'(h);
		hit_exc   = exc_valid && (exc_hart == hid);
		hit_redir = redirect_valid && (redirect_hart == hid);
		if (!awake_exp[h])
			check_flag(instr_valid[h], 1'b0, "word from a sleeping hart");
		if (stall[h])
			check_flag(instr_valid[h], 1'b0, "word delivered under stall");
		if (hit_exc || hit_redir)
			check_flag(instr_valid[h], 1'b0, "word delivered in a redirect cycle");
		if (instr_valid[h])
		begin
			check_flag(l15_transducer_val, 1'b1, "word without a fill return");
			check_rettype(l15_rettype_e'(l15_transducer_returntype), ret_ifill,
				"return type behind a word");
			check_hart(l15_transducer_threadid, hid, "fill return at the wrong hart");
			check_pc(instr_pc[h], exp_pc[h], $sformatf("hart %0d delivered pc", h));
			check_instr(instr[h], swap_bytes(mem_word(exp_pc[h])),
				$sformatf("hart %0d word at %h", h, exp_pc[h]));
			exp_pc[h] = exp_pc[h] + 32'd4;
			delivered[h]++;
		end
		else
		begin
			check_instr(instr[h], nop_instr, $sformatf("hart %0d idle word", h));
		end
		if (hit_exc)
			exp_pc[h] = exc_epc;            // exception wins over redirect
		else if (hit_redir)
			exp_pc[h] = redirect_target;
	endtask

	task automatic watch_responses();
		fill_taken = l15_transducer_val && transducer_l15_req_ack
			&& (l15_transducer_returntype == ret_ifill);
		if (l15_transducer_val)
			check_flag(transducer_l15_req_ack, 1'b1, "response not acknowledged");
		if (l15_transducer_val && (l15_transducer_returntype == ret_int))
			awake_exp[l15_transducer_threadid] = 1'b1;
	endtask

	always @(posedge clk)
	begin
		cycle_cnt++;
		if (cycle_cnt > cycle_limit)
			stop_on_error($sformatf("timeout, run not finished after %0d cycles", cycle_limit));
		if (nrst)
		begin
			watch_port();
			for (int h = 0; h < num_harts; h++)
				watch_hart(h);
			watch_responses();
		end
	end

	task automatic send_fill();
		logic [31:0] base;
		base = {grant_addr[31:4], 4'h0};
		l15_transducer_data_0     = {mem_word(base), mem_word(base + 32'd4)};
		l15_transducer_data_1     = {mem_word(base + 32'd8), mem_word(base + 32'd12)};
		l15_transducer_returntype = ret_ifill;
		l15_transducer_threadid   = grant_tid;
		l15_transducer_val        = 1'b1;
	endtask

	// one cycle of the cache, driven on the falling edge
	task automatic serve_cycle();
		l15_transducer_header_ack = 1'b0;
		l15_transducer_ack        = 1'b0;
		if (cm_state != cm_resp)
			l15_transducer_val = 1'b0;
		else if (fill_taken)
		begin
			l15_transducer_val = 1'b0;
			cm_state           = cm_idle;
		end
		if (cm_state == cm_idle && transducer_l15_val)
		begin
			hold_cnt = next_random(3);
			cm_state = cm_hold;
		end
		if (cm_state == cm_hold)
		begin
			if (hold_cnt == 0)
			begin
				l15_transducer_header_ack = 1'b1;
				l15_transducer_ack        = 1'b1;
				lat_cnt                   = 1 + next_random(3);
				cm_state                  = cm_fill;
			end
			else
			begin
				hold_cnt--;
			end
		end
		else if (cm_state == cm_fill)
		begin
			lat_cnt--;
			if (lat_cnt == 0)
			begin
				send_fill();
				cm_state = cm_resp;
			end
		end
		// interrupt returns take the response bus when no fill holds it
		if (cm_state != cm_resp && wake_q.size() > 0)
		begin
			l15_transducer_returntype = ret_int;
			l15_transducer_threadid   = hart_w'(wake_q.pop_front());
			l15_transducer_val        = 1'b1;
		end
	endtask

	initial
	begin
		lcg_state                 = 32'd77;
		cm_state                  = cm_idle;
		hold_cnt                  = 0;
		lat_cnt                   = 0;
		l15_transducer_header_ack = 1'b0;
		l15_transducer_ack        = 1'b0;
		l15_transducer_val        = 1'b0;
		l15_transducer_data_0     = '0;
		l15_transducer_data_1     = '0;
		l15_transducer_returntype = ret_load;
		l15_transducer_threadid   = '0;
		forever
		begin
			@(negedge clk);
			serve_cycle();
		end
	end

	initial
	begin
		int snap [num_harts];
		int short_hart;
		nrst            = 1'b0;
		redirect_valid  = 1'b0;
		redirect_hart   = '0;
		redirect_target = '0;
		exc_valid       = 1'b0;
		exc_hart        = '0;
		exc_epc         = '0;
		stall           = '0;
		clear_scoreboard();
		load_table();
		cycle_limit = rows.size() * 40 + 200;
		repeat (4) @(posedge clk);
		@(negedge clk);
		nrst = 1'b1;

		foreach (rows[i])
		begin
			repeat (rows[i].offset) @(negedge clk);
			apply_row(rows[i]);
		end

		// let both harts run on past the last command
		for (int h = 0; h < num_harts; h++)
			snap[h] = delivered[h];
		while (delivered[0] < snap[0] + 4 || delivered[1] < snap[1] + 4)
			@(negedge clk);

		short_hart = -1;
		for (int h = 0; h < num_harts; h++)
		begin
			if (delivered[h] < 10)
				short_hart = h;
		end
		if (short_hart >= 0)
			stop_on_error($sformatf("hart %0d delivered only %0d words", short_hart,
				delivered[short_hart]));
		else if (alt_checks < 10)
			stop_on_error($sformatf("only %0d grants with both harts awake", alt_checks));
		else
		begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

// File: fetch_cluster.f
verilog/fetch_pkg.sv
verilog/l15_req_if.sv
verilog/fetch_stage.sv
verilog/redirect_router.sv
verilog/l15_arbiter.sv
verilog/fetch_cluster.sv
test/tb_fetch_cluster.sv

// File: Bender.yml
package:
  name: fetch_cluster

sources:
  - files:
      - verilog/fetch_pkg.sv
      - verilog/l15_req_if.sv
      - verilog/fetch_stage.sv
      - verilog/redirect_router.sv
      - verilog/l15_arbiter.sv
      - verilog/fetch_cluster.sv
  - target: test
    files:
      - test/tb_fetch_cluster.sv
